//--- Bender.yml
package:
  name: header_capture

sources:
  - include_dirs:
      - hw
    files:
      - hw/header_strip_pkg.sv
      - hw/header_splitter.sv
      - hw/beat_fifo.sv
      - hw/stream_output.sv
      - hw/header_capture.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/header_capture_assert.sv
      - verification/header_capture_tb.sv

//--- hw/beat_fifo.sv
`include "header_strip_consts.svh"

module beat_fifo
	import header_strip_pkg::*;
#(
	parameter int depth = `HS_FIFO_DEPTH
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       push,
	input  stream_beat_t               push_beat,
	input  logic                       pop,
	output stream_beat_t               head_beat,
	output logic                       empty,
	output logic [$clog2(depth):0]     free_slots
);
	localparam int ptr_bits = $clog2(depth);

	stream_beat_t          mem [depth];
	logic [ptr_bits-1:0]   wr_ptr;
	logic [ptr_bits-1:0]   rd_ptr;
	logic [ptr_bits:0]     count;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_beat;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap on their own for a power-of-two depth
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_beat = mem[rd_ptr];
	assign empty = (count == '0);
	assign free_slots = (ptr_bits + 1)'(depth) - count;

endmodule

//--- hw/header_capture.sv
`include "header_strip_consts.svh"

module header_capture
	import header_strip_pkg::*;
(
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       in_valid,
	input  stream_beat_t               in_beat,
	output logic                       in_ready,
	output logic                       out_valid,
	output stream_beat_t               out_beat,
	input  logic                       out_ready,
	output logic [`HS_HEADER_BITS-1:0] header_data
);
	localparam int count_bits = $clog2(`HS_FIFO_DEPTH) + 1;

	logic                  push;
	stream_beat_t          push_beat;
	logic                  pop;
	stream_beat_t          head_beat;
	logic                  fifo_empty;
	logic [count_bits-1:0] free_slots;
	logic                  drained;

	header_splitter header_splitter_inst (
		.clock       (clock),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_beat     (in_beat),
		.in_ready    (in_ready),
		.header_data (header_data),
		.push        (push),
		.push_beat   (push_beat),
		.free_slots  (free_slots),
		.fifo_empty  (fifo_empty),
		.drained     (drained)
	);

	beat_fifo #(
		.depth (`HS_FIFO_DEPTH)
	) beat_fifo_inst (
		.clock      (clock),
		.reset      (reset),
		.push       (push),
		.push_beat  (push_beat),
		.pop        (pop),
		.head_beat  (head_beat),
		.empty      (fifo_empty),
		.free_slots (free_slots)
	);

	stream_output stream_output_inst (
		.clock      (clock),
		.reset      (reset),
		.fifo_empty (fifo_empty),
		.head_beat  (head_beat),
		.pop        (pop),
		.out_valid  (out_valid),
		.out_beat   (out_beat),
		.out_ready  (out_ready),
		.drained    (drained)
	);

endmodule

//--- hw/header_splitter.sv
`include "header_strip_consts.svh"

module header_splitter
	import header_strip_pkg::*;
(
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               in_valid,
	input  stream_beat_t                       in_beat,
	output logic                               in_ready,
	output logic [`HS_HEADER_BITS-1:0]         header_data,
	output logic                               push,
	output stream_beat_t                       push_beat,
	input  logic [$clog2(`HS_FIFO_DEPTH):0]    free_slots,
	input  logic                               fifo_empty,
	input  logic                               drained
);
	// one-hot packet states
	localparam logic [4:0] idle       = 5'b00001;
	localparam logic [4:0] capture    = 5'b00010;
	localparam logic [4:0] forward    = 5'b00100;
	localparam logic [4:0] extra_beat = 5'b01000;
	localparam logic [4:0] drain      = 5'b10000;

	logic [4:0]                state;
	beat_view_u                in_view;
	logic [`HS_TAIL_BITS-1:0]  leftover_data;
	logic [`HS_TAIL_BYTES-1:0] leftover_keep;
	logic                      take;
	logic                      tail_empty;
	logic                      room;

	assign in_view.word = in_beat.data;
	assign take = in_valid && in_ready;
	assign tail_empty = (in_beat.keep[`HS_BEAT_BYTES-1:`HS_HEADER_BYTES] == '0);

	// in_ready is a register, so keep a slot for every push already in flight
	// plus the beat it lets in and a possible extra beat after it
	assign room = int'(free_slots) >= 2 + int'(push) + int'(take);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= idle;
			in_ready    <= 1'b0;
			push        <= 1'b0;
			header_data <= '0;
		end else begin
			push <= 1'b0;
			case (state)
				idle: begin
					if (in_valid) begin
						in_ready <= 1'b1;
						state    <= capture;
					end
				end
				capture: begin
					if (take) begin
						header_data <= in_view.split.head;
						if (in_beat.last) begin
							in_ready <= 1'b0;
							state    <= tail_empty ? drain : extra_beat;
						end else begin
							in_ready <= room;
							state    <= forward;
						end
					end else begin
						in_ready <= room;
					end
				end
				forward: begin
					if (take) begin
						push <= 1'b1;
						if (in_beat.last) begin
							in_ready <= 1'b0;
							state    <= tail_empty ? drain : extra_beat;
						end else begin
							in_ready <= room;
						end
					end else begin
						in_ready <= room;
					end
				end
				extra_beat: begin
					push  <= 1'b1;
					state <= drain;
				end
				drain: begin
					// header_data must hold until the last payload beat has left
					if (!push && fifo_empty && drained) begin
						state <= idle;
					end
				end
				default: begin
					in_ready <= 1'b0;
					state    <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			leftover_data <= in_view.split.tail;
			leftover_keep <= in_beat.keep[`HS_BEAT_BYTES-1:`HS_HEADER_BYTES];
		end
		if (state == forward && take) begin
			// current head completes the beat started by the leftover
			push_beat.data <= {in_view.split.head, leftover_data};
			push_beat.keep <= {in_beat.keep[`HS_HEADER_BYTES-1:0], leftover_keep};
			push_beat.last <= in_beat.last && tail_empty;
		end else if (state == extra_beat) begin
			push_beat.data <= {{`HS_HEADER_BITS{1'b0}}, leftover_data};
			push_beat.keep <= {{`HS_HEADER_BYTES{1'b0}}, leftover_keep};
			push_beat.last <= 1'b1;
		end
	end

endmodule

//--- hw/header_strip_consts.svh
`ifndef HEADER_STRIP_CONSTS_SVH
`define HEADER_STRIP_CONSTS_SVH

// beat geometry
`define HS_BEAT_BITS 64
`define HS_BEAT_BYTES 8

// header sits in the low bytes of the first beat
`define HS_HEADER_BITS 24
`define HS_HEADER_BYTES 3

// part of a beat above the header
`define HS_TAIL_BITS 40
`define HS_TAIL_BYTES 5

// beats buffered between splitter and output stage
`define HS_FIFO_DEPTH 16

`endif

//--- hw/header_strip_pkg.sv
`include "header_strip_consts.svh"

package header_strip_pkg;

	// one beat of the byte stream
	typedef struct packed {
		logic [`HS_BEAT_BITS-1:0]  data;
		logic [`HS_BEAT_BYTES-1:0] keep;
		logic                      last;
	} stream_beat_t;

	// same data word, seen whole or cut at the header boundary
	typedef union packed {
		logic [`HS_BEAT_BITS-1:0] word;
		struct packed {
			logic [`HS_TAIL_BITS-1:0]   tail;
			logic [`HS_HEADER_BITS-1:0] head;
		} split;
	} beat_view_u;

endpackage

//--- hw/stream_output.sv
module stream_output
	import header_strip_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  logic         fifo_empty,
	input  stream_beat_t head_beat,
	output logic         pop,
	output logic         out_valid,
	output stream_beat_t out_beat,
	input  logic         out_ready,
	output logic         drained
);
	// refill when the register is free or leaves this cycle
	assign pop = !fifo_empty && (!out_valid || out_ready);

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (pop) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// held while out_ready is low
	always_ff @(posedge clock) begin
		if (pop) begin
			out_beat <= head_beat;
		end
	end

	assign drained = !out_valid && fifo_empty;

endmodule

//--- src.f
+incdir+hw
hw/header_strip_pkg.sv
hw/header_splitter.sv
hw/beat_fifo.sv
hw/stream_output.sv
hw/header_capture.sv
verification/header_capture_assert.sv
verification/header_capture_tb.sv

//--- verification/header_capture_assert.sv
`include "header_strip_consts.svh"

module header_capture_assert
	import header_strip_pkg::*;
(
	input logic                           clock,
	input logic                           reset,
	input logic                           in_ready,
	input logic                           out_valid,
	input stream_beat_t                   out_beat,
	input logic                           out_ready,
	input logic                           push,
	input logic [$clog2(`HS_FIFO_DEPTH):0] free_slots
);
	timeunit 1ns;
	timeprecision 1ps;

	// a stalled beat stays put
	property stall_holds_beat;
		@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_beat);
	endproperty

	property keep_not_empty;
		@(posedge clock) disable iff (reset)
		out_valid |-> out_beat.keep != '0;
	endproperty

	property ready_low_in_reset;
		@(posedge clock) reset |=> !in_ready;
	endproperty

	property no_push_when_full;
		@(posedge clock) disable iff (reset)
		push |-> free_slots != '0;
	endproperty

	stall_check: assert property (stall_holds_beat)
		else $error("out_beat or out_valid changed while out_ready was low");
	keep_check: assert property (keep_not_empty)
		else $error("out_beat.keep is empty on a valid beat");
	reset_check: assert property (ready_low_in_reset)
		else $error("in_ready high during reset");
	full_check: assert property (no_push_when_full)
		else $error("push into a full FIFO");

endmodule

//--- verification/header_capture_tb.sv
`include "header_strip_consts.svh"

module header_capture_tb
	import header_strip_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] seed = 32'hb6407867;
	localparam int packet_count = 40;
	localparam int timeout_cycles = packet_count * 6 * 4 + 200;

	logic                       clock = 1'b0;
	logic                       reset;
	logic                       in_valid;
	stream_beat_t               in_beat;
	logic                       in_ready;
	logic                       out_valid;
	stream_beat_t               out_beat;
	logic                       out_ready = 1'b0;
	logic [`HS_HEADER_BITS-1:0] header_data;

	logic [31:0] in_seed = seed;
	logic [31:0] out_seed = seed ^ 32'h9e3779b9;
	logic        ready_mode = 1'b0;
	int          ready_left = 0;
	int          cycle_count = 0;

	// expected output beats and the header that must be shown with each
	stream_beat_t               exp_beat_q[$];
	logic [`HS_HEADER_BITS-1:0] exp_header_q[$];

	header_capture header_capture_inst (
		.clock       (clock),
		.reset       (reset),
		.in_valid    (in_valid),
		.in_beat     (in_beat),
		.in_ready    (in_ready),
		.out_valid   (out_valid),
		.out_beat    (out_beat),
		.out_ready   (out_ready),
		.header_data (header_data)
	);

	bind header_capture header_capture_assert header_capture_assert_inst (
		.clock      (clock),
		.reset      (reset),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_beat   (out_beat),
		.out_ready  (out_ready),
		.push       (push),
		.free_slots (free_slots)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] keep_for(input int bytes);
		return 8'((1 << bytes) - 1);
	endfunction

	function automatic logic [63:0] data_mask(input logic [7:0] keep);
		logic [63:0] mask;
		for (int j = 0; j < 8; j++) begin
			mask[8*j +: 8] = {8{keep[j]}};
		end
		return mask;
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
				$time, name, got, expected));
		end
	endtask

	// payload bytes packed into full beats, only the final one partial
	task automatic build_expected(input logic [7:0] payload[$],
			input logic [`HS_HEADER_BITS-1:0] header);
		stream_beat_t beat;
		int chunk;
		for (int i = 0; i < payload.size(); i += 8) begin
			chunk = (payload.size() - i < 8) ? payload.size() - i : 8;
			beat = '0;
			for (int j = 0; j < chunk; j++) begin
				beat.data[8*j +: 8] = payload[i + j];
			end
			beat.keep = keep_for(chunk);
			beat.last = (i + chunk == payload.size());
			exp_beat_q.push_back(beat);
			exp_header_q.push_back(header);
		end
	endtask

	// called on a falling edge, returns on the falling edge after the beat is taken
	task automatic drive_beat(input stream_beat_t beat);
		in_valid = 1'b1;
		in_beat = beat;
		while (!in_ready) begin
			@(negedge clock);
		end
		@(negedge clock);
	endtask

	task automatic send_packet();
		int beats;
		int last_bytes;
		int valid_bytes;
		stream_beat_t beat;
		stream_beat_t pkt[$];
		logic [7:0] bytes_q[$];
		logic [7:0] payload[$];
		logic [`HS_HEADER_BITS-1:0] header;
		in_seed = lcg_next(in_seed);
		beats = 1 + int'(in_seed[31:16] % 6);
		in_seed = lcg_next(in_seed);
		last_bytes = 3 + int'(in_seed[31:16] % 6);
		for (int b = 0; b < beats; b++) begin
			in_seed = lcg_next(in_seed);
			beat.data[63:32] = in_seed;
			in_seed = lcg_next(in_seed);
			beat.data[31:0] = in_seed;
			beat.last = (b == beats - 1);
			valid_bytes = beat.last ? last_bytes : 8;
			beat.keep = keep_for(valid_bytes);
			for (int j = 0; j < valid_bytes; j++) begin
				bytes_q.push_back(beat.data[8*j +: 8]);
			end
			pkt.push_back(beat);
		end
		header = {bytes_q[2], bytes_q[1], bytes_q[0]};
		for (int i = `HS_HEADER_BYTES; i < bytes_q.size(); i++) begin
			payload.push_back(bytes_q[i]);
		end
		build_expected(payload, header);
		foreach (pkt[b]) begin
			in_seed = lcg_next(in_seed);
			// occasional idle cycles inside the packet
			if (b > 0 && in_seed[31:30] == 2'b00) begin
				in_valid = 1'b0;
				repeat (1 + int'(in_seed[29])) @(negedge clock);
			end
			drive_beat(pkt[b]);
		end
		in_valid = 1'b0;
	endtask

	task automatic check_output_beat();
		stream_beat_t expected;
		logic [`HS_HEADER_BITS-1:0] header;
		logic [63:0] mask;
		if (exp_beat_q.size() == 0) begin
			report_failure("an output beat appeared with no payload left to send");
		end else begin
			expected = exp_beat_q.pop_front();
			header = exp_header_q.pop_front();
			mask = data_mask(expected.keep);
			check_value("out_beat.keep", out_beat.keep, expected.keep);
			check_value("out_beat.data", out_beat.data & mask, expected.data & mask);
			check_value("out_beat.last", out_beat.last, expected.last);
			check_value("header_data", header_data, header);
		end
	endtask

	// out_ready alternates between random high and low stretches
	always @(negedge clock) begin
		if (ready_left == 0) begin
			out_seed = lcg_next(out_seed);
			ready_mode = out_seed[31];
			if (ready_mode) begin
				ready_left = 1 + int'(out_seed[30:28]);
			end else begin
				ready_left = 1 + int'(out_seed[27:24] % 6);
			end
		end
		out_ready = ready_mode;
		ready_left--;
		if (!reset && out_valid && out_ready) begin
			check_output_beat();
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			report_failure($sformatf("timeout: run did not finish within %0d cycles",
				timeout_cycles));
		end
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_beat = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		// nothing moves before the first in_valid
		repeat (2) begin
			@(negedge clock);
			check_value("in_ready", in_ready, 64'd0);
			check_value("out_valid", out_valid, 64'd0);
		end
		repeat (packet_count) begin
			send_packet();
		end
		while (exp_beat_q.size() != 0) begin
			@(negedge clock);
		end
		// a duplicated beat would be taken in here
		repeat (20) @(negedge clock);
		// nothing left in the output register, splitter back in idle
		check_value("out_valid", out_valid, 64'd0);
		check_value("in_ready", in_ready, 64'd0);
		$display("Testbench passed");
		$finish;
	end

endmodule
